// ==== hw/vdp_mem_pkg.sv ====
// VDP memory shared types
`default_nettype none

package vdp_mem_pkg;

  // sdram geometry: 4 banks x 2048 rows x 256 cols, 32 bit words
  localparam int row_bits       = 11;
  localparam int col_bits       = 8;
  localparam int bank_bits      = 2;
  localparam int word_addr_bits = bank_bits + row_bits + col_bits;  // {bank, row, col}

  // what the host asked for
  typedef enum logic {
    op_read,
    op_write
  } mem_op_e;

  // one request from the bus port to the sequencer
  typedef struct packed {
    mem_op_e                   op;
    logic [word_addr_bits-1:0] addr;   // word address
    logic [31:0]               wdata;  // lane aligned
    logic [3:0]                dqm;    // 1 = lane masked, as on the pins
  } mem_req_t;

  // {cs_n, ras_n, cas_n, we_n}
  typedef enum logic [3:0] {
    cmd_load_mode = 4'b0000,
    cmd_refresh   = 4'b0001,
    cmd_precharge = 4'b0010,
    cmd_activate  = 4'b0011,
    cmd_write     = 4'b0100,
    cmd_read      = 4'b0101,
    cmd_nop       = 4'b0111,
    cmd_deselect  = 4'b1111
  } sdram_cmd_e;

  // control pins, all flopped on the rising edge of clk
  typedef struct packed {
    logic                 cke;
    sdram_cmd_e           cmd;
    logic [bank_bits-1:0] ba;
    logic [row_bits-1:0]  addr;  // row on activate, a10 = auto precharge on rd/wr
    logic [3:0]           dqm;
  } sdram_bus_t;

endpackage

`default_nettype wire

// ==== hw/wb_sdram_port.sv ====
// Wishbone classic slave for the SDRAM
`default_nettype none

module wb_sdram_port (
  input  wire                                      clk,
  input  wire                                      resetn,
  input  wire                                      wb_cyc,
  input  wire                                      wb_stb,
  input  wire                                      wb_we,
  input  wire        [vdp_mem_pkg::word_addr_bits-1:0] wb_adr,
  input  wire        [3:0]                         wb_sel,
  input  wire        [31:0]                        wb_dat_w,
  input  wire                                      req_done,
  input  wire        [31:0]                        rdata,
  output logic       [31:0]                        wb_dat_r,
  output logic                                     wb_ack,
  output logic                                     wb_err,
  output logic                                     req_valid,
  output vdp_mem_pkg::mem_req_t                    req
);

  logic        sel_ok;     // select is one of the supported sizes
  logic        start;      // new bus cycle seen this clock
  logic [31:0] lane_mask;  // selected read lanes

  // only aligned byte, halfword and word selects are legal
  always_comb begin
    case (wb_sel)
      4'b0001, 4'b0010, 4'b0100, 4'b1000: sel_ok = 1'b1;
      4'b0011, 4'b1100:                   sel_ok = 1'b1;
      4'b1111:                            sel_ok = 1'b1;
      default:                            sel_ok = 1'b0;
    endcase
  end

  // ack/err still high means stb is from the finished cycle, don't restart
  assign start = wb_cyc && wb_stb && !req_valid && !wb_ack && !wb_err;

  assign lane_mask = {{8{wb_sel[3]}}, {8{wb_sel[2]}}, {8{wb_sel[1]}}, {8{wb_sel[0]}}};

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      req_valid <= 1'b0;
      wb_ack    <= 1'b0;
      wb_err    <= 1'b0;
    end else begin
      wb_ack <= req_valid && req_done;  // one cycle after the sequencer is done
      wb_err <= start && !sel_ok;       // bad select never reaches the sdram
      if (start && sel_ok) begin
        req_valid <= 1'b1;
      end else if (req_done) begin
        req_valid <= 1'b0;
      end
    end
  end

  // request payload and read data
  always_ff @(posedge clk) begin
    if (start) begin
      req.op    <= wb_we ? vdp_mem_pkg::op_write : vdp_mem_pkg::op_read;
      req.addr  <= wb_adr;
      req.wdata <= wb_dat_w;
      req.dqm   <= ~wb_sel;  // sdram mask is active high
    end
    if (req_done) begin
      wb_dat_r <= rdata & lane_mask;  // unselected lanes read as zero
    end
  end

  // the two responses come from separate paths
  a_ack_err_excl: assert property (@(posedge clk) disable iff (!resetn)
    !(wb_ack && wb_err));

  // master holds cyc/stb until it sees ack
  a_ack_in_cycle: assert property (@(posedge clk) disable iff (!resetn)
    wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire

// ==== hw/sdram_ctrl.sv ====
// SDRAM sequencer, closed page
`default_nettype none

module sdram_ctrl #(
  parameter int freq_hz     = 25_000_000,
  parameter int cas_latency = 2
) (
  input  wire                          clk,
  input  wire                          resetn,
  input  wire                          req_valid,
  input  wire vdp_mem_pkg::mem_req_t   req,
  output logic                         req_done,
  output logic [31:0]                  rdata,
  output logic                         ready,
  output logic                         sdram_clk,
  output vdp_mem_pkg::sdram_bus_t      sdram_bus,
  inout  wire  [31:0]                  sdram_dq
);

  localparam int init_cycles = freq_hz / 5_000;  // 200 us power-up wait
  // 7.8 us, less room for one access in flight when the timer fires
  localparam int refresh_cycles = (freq_hz / 10_000) * 78 / 1_000 - 16;

  // core timings in clocks, safe up to ~133 MHz
  localparam int t_rcd = 2;
  localparam int t_rp  = 2;
  localparam int t_wr  = 2;
  localparam int t_rfc = 8;
  localparam int t_mrd = 2;

  localparam int cnt_bits = $clog2(init_cycles + 1);
  localparam int ref_bits = $clog2(refresh_cycles + 1);

  // burst 1, sequential, cas latency, standard mode
  localparam logic [vdp_mem_pkg::row_bits-1:0] mode_word = {4'b0000, 3'(cas_latency), 4'b0000};

  typedef enum logic [3:0] {
    init_wait,
    init_precharge,
    init_refresh,
    init_mode,
    idle,
    activate,
    rw,
    cas_wait,
    precharge_wait,
    refresh
  } state_e;

  state_e                              state;
  logic [cnt_bits-1:0]                 cnt;          // shared delay counter
  logic [ref_bits-1:0]                 ref_cnt;
  logic                                ref_pending;
  logic                                ref_take;
  logic                                second_ref;   // init needs two refreshes
  logic                                dq_oe;
  logic [31:0]                         dq_out;
  logic [vdp_mem_pkg::bank_bits-1:0]   req_bank;
  logic [vdp_mem_pkg::row_bits-1:0]    req_row;
  logic [vdp_mem_pkg::col_bits-1:0]    req_col;

  // address split, bank on top, column at the bottom
  assign req_bank = req.addr[vdp_mem_pkg::word_addr_bits-1 -: vdp_mem_pkg::bank_bits];
  assign req_row  = req.addr[vdp_mem_pkg::col_bits +: vdp_mem_pkg::row_bits];
  assign req_col  = req.addr[vdp_mem_pkg::col_bits-1:0];

  assign sdram_clk = ~clk;  // sdram samples mid-cycle
  assign sdram_dq  = dq_oe ? dq_out : 'z;
  assign ref_take  = (state == idle) && ref_pending;

  // refresh timer
  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      ref_cnt     <= ref_bits'(refresh_cycles - 1);
      ref_pending <= 1'b0;
    end else begin
      if (ref_take) ref_pending <= 1'b0;
      if (ref_cnt == '0) begin
        ref_cnt     <= ref_bits'(refresh_cycles - 1);
        ref_pending <= 1'b1;  // wins over a take in the same cycle
      end else begin
        ref_cnt <= ref_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state      <= init_wait;
      cnt        <= cnt_bits'(init_cycles - 1);
      second_ref <= 1'b0;
      ready      <= 1'b0;
      req_done   <= 1'b0;
      dq_oe      <= 1'b0;
      sdram_bus  <= '{cke: 1'b0, cmd: vdp_mem_pkg::cmd_deselect, ba: '0, addr: '0, dqm: 4'hf};
    end else begin
      sdram_bus.cmd <= vdp_mem_pkg::cmd_nop;  // one-cycle commands
      sdram_bus.dqm <= {4{~ready}};           // masked until init is done
      req_done      <= 1'b0;
      dq_oe         <= 1'b0;
      if (cnt != '0) cnt <= cnt - 1'b1;
      case (state)
        init_wait: begin
          sdram_bus.cke <= 1'b1;
          if (cnt == '0) begin
            sdram_bus.cmd     <= vdp_mem_pkg::cmd_precharge;
            sdram_bus.addr    <= '0;
            sdram_bus.addr[10] <= 1'b1;  // all banks
            cnt   <= cnt_bits'(t_rp - 1);
            state <= init_precharge;
          end
        end
        init_precharge: if (cnt == '0) begin
          sdram_bus.cmd <= vdp_mem_pkg::cmd_refresh;
          cnt        <= cnt_bits'(t_rfc - 1);
          second_ref <= 1'b1;
          state      <= init_refresh;
        end
        init_refresh: if (cnt == '0) begin
          if (second_ref) begin
            sdram_bus.cmd <= vdp_mem_pkg::cmd_refresh;
            cnt        <= cnt_bits'(t_rfc - 1);
            second_ref <= 1'b0;
          end else begin
            sdram_bus.cmd  <= vdp_mem_pkg::cmd_load_mode;
            sdram_bus.ba   <= '0;
            sdram_bus.addr <= mode_word;
            cnt   <= cnt_bits'(t_mrd - 1);
            state <= init_mode;
          end
        end
        init_mode: if (cnt == '0) begin
          ready <= 1'b1;
          state <= idle;
        end
        idle: begin
          if (ref_pending) begin  // refresh first
            sdram_bus.cmd <= vdp_mem_pkg::cmd_refresh;
            cnt   <= cnt_bits'(t_rfc - 1);
            state <= refresh;
          end else if (req_valid && !req_done) begin  // req_valid drops a cycle after done
            sdram_bus.cmd  <= vdp_mem_pkg::cmd_activate;
            sdram_bus.ba   <= req_bank;
            sdram_bus.addr <= req_row;
            cnt   <= cnt_bits'(t_rcd - 1);
            state <= activate;
          end
        end
        activate: if (cnt == '0) begin
          sdram_bus.cmd <= (req.op == vdp_mem_pkg::op_write) ? vdp_mem_pkg::cmd_write
                                                             : vdp_mem_pkg::cmd_read;
          sdram_bus.addr     <= vdp_mem_pkg::row_bits'(req_col);
          sdram_bus.addr[10] <= 1'b1;  // auto precharge
          sdram_bus.dqm      <= (req.op == vdp_mem_pkg::op_write) ? req.dqm : 4'h0;
          dq_oe <= (req.op == vdp_mem_pkg::op_write);  // drive only in the write cycle
          state <= rw;
        end
        rw: begin
          if (req.op == vdp_mem_pkg::op_read) begin
            cnt   <= cnt_bits'(cas_latency - 1);
            state <= cas_wait;
          end else begin
            cnt   <= cnt_bits'(t_wr + t_rp - 1);  // write recovery then precharge
            state <= precharge_wait;
          end
        end
        cas_wait: if (cnt == '0) begin  // data captured on this edge
          cnt   <= cnt_bits'(t_rp - 1);
          state <= precharge_wait;
        end
        precharge_wait: if (cnt == '0) begin
          req_done <= 1'b1;
          state    <= idle;
        end
        refresh: if (cnt == '0) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // write data and read capture
  always_ff @(posedge clk) begin
    if (state == activate) dq_out <= req.wdata;
    if (state == cas_wait && cnt == '0) rdata <= sdram_dq;  // cas_latency after read
  end

  // column commands only once init is through
  a_no_rw_before_ready: assert property (@(posedge clk) disable iff (!resetn)
    (sdram_bus.cmd inside {vdp_mem_pkg::cmd_read, vdp_mem_pkg::cmd_write}) |-> ready);

  // nothing but nop inside t_rcd after an activate
  a_rcd_gap: assert property (@(posedge clk) disable iff (!resetn)
    (sdram_bus.cmd == vdp_mem_pkg::cmd_activate) |=>
      (sdram_bus.cmd == vdp_mem_pkg::cmd_nop) [*(t_rcd - 1)]);

endmodule

`default_nettype wire

// ==== hw/vdp_mem_top.sv ====
// VDP memory subsystem top
`default_nettype none

module vdp_mem_top #(
  parameter int freq_hz     = 25_000_000,
  parameter int cas_latency = 2
) (
  input  wire                                    clk,
  input  wire                                    resetn,
  input  wire                                    wb_cyc,
  input  wire                                    wb_stb,
  input  wire                                    wb_we,
  input  wire  [vdp_mem_pkg::word_addr_bits-1:0] wb_adr,
  input  wire  [3:0]                             wb_sel,
  input  wire  [31:0]                            wb_dat_w,
  output logic [31:0]                            wb_dat_r,
  output logic                                   wb_ack,
  output logic                                   wb_err,
  output logic                                   ready,      // init done
  output logic                                   sdram_clk,
  output vdp_mem_pkg::sdram_bus_t                sdram_bus,
  inout  wire  [31:0]                            sdram_dq
);

  // port to sequencer handshake
  logic                  req_valid;
  logic                  req_done;
  logic [31:0]           rdata;
  vdp_mem_pkg::mem_req_t req;

  wb_sdram_port u_port (
    .clk       (clk),
    .resetn    (resetn),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_sel    (wb_sel),
    .wb_dat_w  (wb_dat_w),
    .req_done  (req_done),
    .rdata     (rdata),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack),
    .wb_err    (wb_err),
    .req_valid (req_valid),
    .req       (req)
  );

  sdram_ctrl #(
    .freq_hz     (freq_hz),
    .cas_latency (cas_latency)
  ) u_ctrl (
    .clk       (clk),
    .resetn    (resetn),
    .req_valid (req_valid),
    .req       (req),
    .req_done  (req_done),
    .rdata     (rdata),
    .ready     (ready),
    .sdram_clk (sdram_clk),
    .sdram_bus (sdram_bus),
    .sdram_dq  (sdram_dq)
  );

endmodule

`default_nettype wire

// ==== tests/sdram_model.sv ====
// Behavioral x32 SDRAM
`default_nettype none

module sdram_model #(
  parameter int cas_latency    = 2,
  parameter int refresh_max_ns = 7_800  // longest allowed gap between refreshes
) (
  input  wire                          sdram_clk,
  input  wire vdp_mem_pkg::sdram_bus_t sdram_bus,
  inout  wire [31:0]                   sdram_dq,
  output logic                         fault
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int t_rcd = 2;

  logic [31:0]                      mem [int];   // sparse, only written words
  logic [vdp_mem_pkg::row_bits-1:0] open_row [4];
  logic [3:0]                       bank_open = '0;
  int                               act_cycle [4];
  int                               cycle     = 0;
  bit                               mode_set  = 1'b0;
  bit                               ref_seen  = 1'b0;
  bit                               fault_q   = 1'b0;
  realtime                          last_ref  = 0;
  int                               rd_cnt    = 0;  // edges until read data appears
  logic [31:0]                      rd_word;
  logic [31:0]                      dq_q;
  logic                             dq_oe     = 1'b0;
  logic [31:0]                      word;
  logic [20:0]                      waddr;       // {bank, row, col}

  assign sdram_dq = dq_oe ? dq_q : 'z;
  assign fault    = fault_q;

  // contents of a word never written
  function automatic logic [31:0] fill_word(input logic [20:0] a);
    return {~a[10:0], a};
  endfunction

  task automatic report(input string what);
    $display("sdram model: %s at %0t ns", what, $time);
    fault_q = 1'b1;
  endtask

  always @(posedge sdram_clk) begin
    cycle = cycle + 1;
    dq_oe = 1'b0;
    if (rd_cnt > 0) begin
      rd_cnt = rd_cnt - 1;
      if (rd_cnt == 0) begin  // cas latency reached, drive for one cycle
        dq_oe = 1'b1;
        dq_q  = rd_word;
      end
    end
    if (ref_seen && !fault_q && ($realtime - last_ref) > refresh_max_ns)
      report("refresh starved");
    if (sdram_bus.cke === 1'b1) begin
      waddr = {sdram_bus.ba, open_row[sdram_bus.ba], sdram_bus.addr[vdp_mem_pkg::col_bits-1:0]};
      case (sdram_bus.cmd)
        vdp_mem_pkg::cmd_activate: begin
          if (!mode_set) report("activate before the mode register was set");
          if (bank_open[sdram_bus.ba]) report("activate on a bank that is already open");
          bank_open[sdram_bus.ba] = 1'b1;
          open_row[sdram_bus.ba]  = sdram_bus.addr;
          act_cycle[sdram_bus.ba] = cycle;
        end
        vdp_mem_pkg::cmd_read, vdp_mem_pkg::cmd_write: begin
          if (!bank_open[sdram_bus.ba]) report("read or write to a closed bank");
          if (cycle - act_cycle[sdram_bus.ba] < t_rcd) report("read or write inside t_rcd");
          word = mem.exists(int'(waddr)) ? mem[int'(waddr)] : fill_word(waddr);
          if (sdram_bus.cmd == vdp_mem_pkg::cmd_write) begin
            for (int i = 0; i < 4; i++)
              if (!sdram_bus.dqm[i]) word[i*8 +: 8] = sdram_dq[i*8 +: 8];  // dqm high keeps lane
            mem[int'(waddr)] = word;
          end else begin
            rd_word = word;
            rd_cnt  = cas_latency;
          end
          if (sdram_bus.addr[10]) bank_open[sdram_bus.ba] = 1'b0;  // auto precharge
        end
        vdp_mem_pkg::cmd_precharge: begin
          if (sdram_bus.addr[10]) bank_open = '0;
          else bank_open[sdram_bus.ba] = 1'b0;
        end
        vdp_mem_pkg::cmd_refresh: begin
          if (|bank_open) report("refresh with a bank still open");
          ref_seen = 1'b1;
          last_ref = $realtime;
        end
        vdp_mem_pkg::cmd_load_mode: begin
          if (sdram_bus.addr[6:4] != 3'(cas_latency)) report("mode register cas latency wrong");
          mode_set = 1'b1;
        end
        default: ;  // nop, deselect
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_vdp_mem.sv ====
// VDP memory subsystem testbench
`default_nettype none

module tb_vdp_mem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ready_timeout  = 6_000;  // cycles, init is about 5000
  localparam int xfer_timeout   = 200;
  localparam int refresh_cycles = 195;    // 7.8 us at 25 MHz
  localparam vdp_mem_pkg::mem_op_e wr = vdp_mem_pkg::op_write;
  localparam vdp_mem_pkg::mem_op_e rd = vdp_mem_pkg::op_read;

  typedef struct packed {
    vdp_mem_pkg::mem_op_e op;
    logic [20:0]          adr;
    logic [3:0]           sel;
    logic [31:0]          wdata;
    logic                 expect_err;
  } xfer_t;

  logic                    clk = 1'b0;
  logic                    resetn, wb_cyc, wb_stb, wb_we;
  logic [20:0]             wb_adr;
  logic [3:0]              wb_sel;
  logic [31:0]             wb_dat_w, wb_dat_r;
  logic                    wb_ack, wb_err, ready, sdram_clk;
  vdp_mem_pkg::sdram_bus_t sdram_bus;
  wire  [31:0]             sdram_dq;
  wire                     model_fault;

  xfer_t       table_q [$];
  string       name_q [$];
  logic [31:0] ref_mem [int];  // expected sdram contents
  int          fail_count = 0;

  vdp_mem_top #(.freq_hz(25_000_000), .cas_latency(2)) u_dut (
    .clk(clk), .resetn(resetn), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r),
    .wb_ack(wb_ack), .wb_err(wb_err), .ready(ready), .sdram_clk(sdram_clk),
    .sdram_bus(sdram_bus), .sdram_dq(sdram_dq)
  );

  sdram_model #(.cas_latency(2)) u_sdram (
    .sdram_clk(sdram_clk), .sdram_bus(sdram_bus), .sdram_dq(sdram_dq), .fault(model_fault)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_count++;
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  always @(posedge model_fault) abort_run("sdram model flagged a refresh or command order error");

  // power-up value of a word, same convention as the model
  function automatic logic [31:0] stored(input logic [20:0] a);
    return ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : {~a[10:0], a};
  endfunction

  function automatic logic [31:0] lanes_of(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  task automatic add_row(input string name, input vdp_mem_pkg::mem_op_e op,
                         input logic [20:0] adr, input logic [3:0] sel,
                         input logic [31:0] wdata, input logic expect_err);
    name_q.push_back(name);
    table_q.push_back('{op: op, adr: adr, sel: sel, wdata: wdata, expect_err: expect_err});
  endtask

  task automatic wait_ready();
    int waited;
    waited = 0;
    while (ready !== 1'b1) begin
      if (wb_ack || wb_err) abort_run("bus response seen before ready");
      if (waited == ready_timeout) abort_run("ready did not rise after reset");
      waited++;
      @(negedge clk);
    end
  endtask

  // one wishbone classic cycle, checked against the reference memory
  task automatic run_xfer(input string name, input xfer_t x);
    int          waited;
    logic        got_ack;
    logic        got_err;
    logic [31:0] got_data;
    logic [31:0] lanes;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = (x.op == wr);
    wb_adr   = x.adr;
    wb_sel   = x.sel;
    wb_dat_w = x.wdata;
    waited   = 0;
    @(negedge clk);
    while (!wb_ack && !wb_err) begin
      if (waited == xfer_timeout) abort_run($sformatf("no ack or err for %s", name));
      waited++;
      @(negedge clk);
    end
    got_ack  = wb_ack;
    got_err  = wb_err;
    got_data = wb_dat_r;
    @(negedge clk);  // stb drops in the cycle after the response
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    check_value({name, " err"}, 32'(x.expect_err), 32'(got_err));
    check_value({name, " ack"}, 32'(!x.expect_err), 32'(got_ack));
    lanes = lanes_of(x.sel);
    if (!x.expect_err) begin
      if (x.op == wr) ref_mem[int'(x.adr)] = (stored(x.adr) & ~lanes) | (x.wdata & lanes);
      else check_value(name, stored(x.adr) & lanes, got_data);
    end
  endtask

  initial begin
    int          seed;
    logic [31:0] r;
    logic [20:0] rnd_adr [32];
    seed     = 91547;
    resetn   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_sel   = '0;
    wb_dat_w = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    wait_ready();

    add_row("word_wr_a",   wr, 21'h00_0010, 4'b1111, 32'hdead_beef, 1'b0);
    add_row("word_rd_a",   rd, 21'h00_0010, 4'b1111, 32'h0,         1'b0);
    add_row("neighbor_rd", rd, 21'h00_0011, 4'b1111, 32'h0,         1'b0);
    add_row("word_wr_b",   wr, 21'h1a_5f3c, 4'b1111, 32'h0bad_f00d, 1'b0);
    add_row("byte0_wr",    wr, 21'h00_0010, 4'b0001, 32'h0000_00aa, 1'b0);
    add_row("byte2_wr",    wr, 21'h00_0010, 4'b0100, 32'h00cc_0000, 1'b0);
    add_row("half_hi_wr",  wr, 21'h1a_5f3c, 4'b1100, 32'h1234_0000, 1'b0);
    add_row("half_lo_wr",  wr, 21'h09_8001, 4'b0011, 32'h0000_5678, 1'b0);
    add_row("word_rd_a2",  rd, 21'h00_0010, 4'b1111, 32'h0,         1'b0);
    add_row("word_rd_b2",  rd, 21'h1a_5f3c, 4'b1111, 32'h0,         1'b0);
    add_row("word_rd_c",   rd, 21'h09_8001, 4'b1111, 32'h0,         1'b0);
    add_row("byte1_rd",    rd, 21'h00_0010, 4'b0010, 32'h0,         1'b0);
    add_row("byte3_rd",    rd, 21'h00_0010, 4'b1000, 32'h0,         1'b0);
    add_row("half_lo_rd",  rd, 21'h1a_5f3c, 4'b0011, 32'h0,         1'b0);
    add_row("half_hi_rd",  rd, 21'h1a_5f3c, 4'b1100, 32'h0,         1'b0);
    add_row("sel0000_wr",  wr, 21'h00_0010, 4'b0000, 32'hffff_ffff, 1'b1);
    add_row("sel0101_wr",  wr, 21'h00_0010, 4'b0101, 32'hffff_ffff, 1'b1);
    add_row("sel0111_rd",  rd, 21'h00_0010, 4'b0111, 32'h0,         1'b1);
    add_row("word_rd_a3",  rd, 21'h00_0010, 4'b1111, 32'h0,         1'b0);
    foreach (table_q[i]) run_xfer(name_q[i], table_q[i]);

    // random words, bank taken from the index so all four get traffic
    for (int i = 0; i < 32; i++) begin
      r          = $random(seed);
      rnd_adr[i] = {2'(i), r[18:0]};
      r          = $random(seed);
      run_xfer($sformatf("rand_wr_%0d", i), '{wr, rnd_adr[i], 4'b1111, r, 1'b0});
    end
    for (int i = 0; i < 32; i++)
      run_xfer($sformatf("rand_rd_%0d", i), '{rd, rnd_adr[i], 4'b1111, 32'h0, 1'b0});
    repeat (5 * refresh_cycles) @(negedge clk);  // only auto refresh keeps data now
    for (int i = 0; i < 32; i++)
      run_xfer($sformatf("rand_reread_%0d", i), '{rd, rnd_adr[i], 4'b1111, 32'h0, 1'b0});

    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
hw/vdp_mem_pkg.sv
hw/wb_sdram_port.sv
hw/sdram_ctrl.sv
hw/vdp_mem_top.sv
tests/sdram_model.sv
tests/tb_vdp_mem.sv

// ==== Bender.yml ====
package:
  name: vdp_mem

sources:
  - hw/vdp_mem_pkg.sv
  - hw/wb_sdram_port.sv
  - hw/sdram_ctrl.sv
  - hw/vdp_mem_top.sv
  - target: test
    files:
      - tests/sdram_model.sv
      - tests/tb_vdp_mem.sv
